// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= dcache_tb
FILELIST  ?= dcache_top.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for a pass"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: dcache_top.f
+incdir+design
design/dcache_pkg.sv
design/sram_64x128.sv
design/dcache_data.sv
design/dcache_tag.sv
design/dcache_ctrl.sv
design/dcache_top.sv
testbench/dcache_tb.sv

// File: design/dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// CPU address split into tag, set index and byte offset
`define DCACHE_ADDR_W  32
`define DCACHE_IDX_LEN 6
`define DCACHE_BLK_LEN 6
`define DCACHE_TAG_LEN 20

// Number of sets, one SRAM row per set in every bank
`define DCACHE_SETS    64

// Data path widths
`define DCACHE_XLEN    64
`define DCACHE_BANK_W  128

// A 64-byte line spread over four 128-bit banks
`define DCACHE_BANKS   4

// 64-bit beats per line on the memory side
`define DCACHE_BEATS   8

`endif

// File: design/dcache_ctrl.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_ctrl
  import dcache_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic                      req_i,
  input  cpu_req_t                  cpu_req_i,
  output logic                      done_o,
  input  logic                      hit_i,
  input  logic                      dirty_i,
  input  tag_t                      victim_tag_i,
  output logic                      tag_refill_o,
  output logic                      tag_set_dirty_o,
  output index_t                    index_o,
  output blk_off_t                  blk_addr_o,
  output bank_word_t                line_wdata_o,
  output bank_word_t                wmask_o,
  output beat_t                     burst_count_o,
  output logic                      allocate_valid_o,
  output logic                      writeback_valid_o,
  output logic                      wen_o,
  output logic                      mem_rd_o,
  output logic                      mem_wr_o,
  output logic [`DCACHE_ADDR_W-1:0] mem_addr_o,
  input  word_t                     mem_rdata_i,
  input  logic                      mem_beat_i
);

  dcache_state_e state_q;
  dcache_state_e state_d;
  cpu_req_t      req_q;
  beat_t         count_q;
  cache_addr_t   cur_addr;
  cache_addr_t   line_addr;
  word_t         strb_bits;
  bank_word_t    store_mask;
  bank_word_t    refill_mask;
  logic          bursting;
  logic          last_beat;

  assign bursting  = (state_q == WRITEBACK) || (state_q == REFILL);
  assign last_beat = mem_beat_i && (count_q == beat_t'(`DCACHE_BEATS - 1));

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == IDLE && req_i) begin
      req_q <= cpu_req_i;
    end
  end

  // Wraps back to zero after the eighth beat
  always_ff @(posedge clk) begin
    if (rst_i) begin
      count_q <= '0;
    end else if (bursting && mem_beat_i) begin
      count_q <= count_q + 1'b1;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req_i) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        if (hit_i) begin
          state_d = req_q.we ? STORE : IDLE;
        end else if (dirty_i) begin
          state_d = WRITEBACK;
        end else begin
          state_d = REFILL;
        end
      end
      STORE: state_d = IDLE;
      WRITEBACK: begin
        if (last_beat) begin
          state_d = REFILL;
        end
      end
      REFILL: begin
        if (last_beat) begin
          state_d = REPLAY;
        end
      end
      // Re-read the new line, then finish as a hit
      REPLAY: state_d = LOOKUP;
      default: state_d = IDLE;
    endcase
  end

  // The SRAM and tag store see the live request while idle
  assign cur_addr   = (state_q == IDLE) ? cpu_req_i.addr : req_q.addr;
  assign index_o    = cur_addr.index;
  assign blk_addr_o = cur_addr.offset;

  // Byte strobes to a bit mask on the half picked by offset bit 3
  always_comb begin
    for (int i = 0; i < `DCACHE_XLEN / 8; i++) begin
      strb_bits[i*8 +: 8] = {8{req_q.wstrb[i]}};
    end
  end

  assign store_mask  = req_q.addr.offset[3] ? {strb_bits, word_t'(0)}
                                            : {word_t'(0), strb_bits};
  assign refill_mask = count_q[0] ? {{`DCACHE_XLEN{1'b1}}, word_t'(0)}
                                  : {word_t'(0), {`DCACHE_XLEN{1'b1}}};

  // Word copied into both halves, the mask keeps one
  assign line_wdata_o = {2{(state_q == REFILL) ? mem_rdata_i : req_q.wdata}};
  assign wmask_o      = (state_q == REFILL) ? refill_mask : store_mask;
  assign wen_o        = (state_q == STORE) || ((state_q == REFILL) && mem_beat_i);

  assign burst_count_o     = count_q;
  assign allocate_valid_o  = (state_q == REFILL);
  assign writeback_valid_o = (state_q == WRITEBACK);

  assign tag_refill_o    = (state_q == REFILL) && last_beat;
  assign tag_set_dirty_o = (state_q == STORE);

  assign done_o = (state_q == STORE) || ((state_q == LOOKUP) && hit_i && !req_q.we);

  // Victim line while writing back, request line otherwise
  assign line_addr.tag    = (state_q == WRITEBACK) ? victim_tag_i : req_q.addr.tag;
  assign line_addr.index  = req_q.addr.index;
  assign line_addr.offset = '0;

  assign mem_addr_o = line_addr;
  assign mem_rd_o   = (state_q == REFILL);
  assign mem_wr_o   = (state_q == WRITEBACK);

  a_mem_excl: assert property (@(posedge clk) disable iff (rst_i)
    !(mem_rd_o && mem_wr_o))
    else $error("mem_rd_o and mem_wr_o both high");

  a_req_aligned: assert property (@(posedge clk) disable iff (rst_i)
    req_i |-> cpu_req_i.addr.offset[2:0] == 3'b000)
    else $error("misaligned request");

  // CPU only issues while the cache is idle
  a_req_idle: assert property (@(posedge clk) disable iff (rst_i)
    req_i |-> state_q == IDLE)
    else $error("request while busy");

endmodule

// File: design/dcache_data.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_data
  import dcache_pkg::*;
(
  input  logic       clk,
  input  index_t     index_i,
  input  blk_off_t   blk_addr_i,
  input  bank_word_t line_wdata_i,
  input  bank_word_t wmask_i,
  input  beat_t      burst_count_i,
  input  logic       allocate_valid_i,
  input  logic       writeback_valid_i,
  input  logic       wen_i,
  output sram_port_t sram_o [`DCACHE_BANKS],
  input  bank_word_t sram_rdata_i [`DCACHE_BANKS],
  output word_t      writeback_data_o,
  output word_t      rdata_o
);

  logic [`DCACHE_BANKS-1:0] alloc_sel;
  logic [`DCACHE_BANKS-1:0] hit_sel;
  logic [`DCACHE_BANKS-1:0] bank_we;
  bank_word_t               hit_word;
  bank_word_t               wb_word;

  // Refill picks the bank from the beat counter,
  // a CPU access from offset bits [5:4]
  always_comb begin
    alloc_sel = '0;
    hit_sel   = '0;
    if (allocate_valid_i) begin
      alloc_sel[burst_count_i[2:1]] = 1'b1;
    end else if (!writeback_valid_i) begin
      hit_sel[blk_addr_i[5:4]] = 1'b1;
    end
  end

  assign bank_we = (alloc_sel | hit_sel) & {`DCACHE_BANKS{wen_i}};

  // A write selects only the target bank
  // Otherwise all four banks read the set, so the whole line is
  // already on the read ports when a writeback starts
  always_comb begin
    for (int b = 0; b < `DCACHE_BANKS; b++) begin
      sram_o[b].addr  = index_i;
      sram_o[b].cen   = wen_i ? !bank_we[b] : 1'b0;
      sram_o[b].wen   = !bank_we[b];
      sram_o[b].wmask = wmask_i;
      sram_o[b].wdata = line_wdata_i;
    end
  end

  // Load word, AND-OR over the hit bank then the half by offset bit 3
  always_comb begin
    hit_word = '0;
    for (int b = 0; b < `DCACHE_BANKS; b++) begin
      hit_word = hit_word | ({`DCACHE_BANK_W{hit_sel[b]}} & sram_rdata_i[b]);
    end
  end

  assign rdata_o = blk_addr_i[3] ? hit_word[`DCACHE_BANK_W-1:`DCACHE_XLEN]
                                 : hit_word[`DCACHE_XLEN-1:0];

  // Beat n lives in bank n/2, upper half when n is odd
  assign wb_word = sram_rdata_i[burst_count_i[2:1]];

  assign writeback_data_o = burst_count_i[0] ? wb_word[`DCACHE_BANK_W-1:`DCACHE_XLEN]
                                             : wb_word[`DCACHE_XLEN-1:0];

  // Refill and writeback come from different controller states
  a_alloc_wb_excl: assert property (@(posedge clk)
    !(allocate_valid_i === 1'b1 && writeback_valid_i === 1'b1))
    else $error("allocate and writeback both active");

  a_one_bank_write: assert property (@(posedge clk)
    $isunknown(bank_we) || $onehot0(bank_we))
    else $error("more than one bank written in a cycle");

endmodule

// File: design/dcache_pkg.sv
`include "dcache_consts.svh"

package dcache_pkg;

  typedef logic [`DCACHE_TAG_LEN-1:0]        tag_t;
  typedef logic [`DCACHE_IDX_LEN-1:0]        index_t;
  typedef logic [`DCACHE_BLK_LEN-1:0]        blk_off_t;
  typedef logic [`DCACHE_XLEN-1:0]           word_t;
  typedef logic [`DCACHE_XLEN/8-1:0]         strb_t;
  typedef logic [`DCACHE_BANK_W-1:0]         bank_word_t;
  typedef logic [$clog2(`DCACHE_BEATS)-1:0]  beat_t;

  // Tag in the top bits, byte offset in the bottom
  typedef struct packed {
    tag_t     tag;
    index_t   index;
    blk_off_t offset;
  } cache_addr_t;

  typedef struct packed {
    logic        we;
    cache_addr_t addr;
    word_t       wdata;
    strb_t       wstrb;
  } cpu_req_t;

  // Inputs of one SRAM bank; cen and wen are active low
  typedef struct packed {
    index_t     addr;
    logic       cen;
    logic       wen;
    bank_word_t wmask;
    bank_word_t wdata;
  } sram_port_t;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    STORE,
    WRITEBACK,
    REFILL,
    REPLAY
  } dcache_state_e;

endpackage

// File: design/dcache_tag.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_tag
  import dcache_pkg::*;
(
  input  logic   clk,
  input  logic   rst_i,
  input  index_t index_i,
  input  tag_t   tag_i,
  input  logic   refill_i,
  input  logic   set_dirty_i,
  output logic   hit_o,
  output logic   dirty_o,
  output tag_t   victim_tag_o
);

  tag_t                    tag_mem [0:`DCACHE_SETS-1];
  logic [`DCACHE_SETS-1:0] valid_q;
  logic [`DCACHE_SETS-1:0] dirty_q;
  index_t                  idx_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_q <= '0;
    end else if (refill_i) begin
      valid_q[index_i] <= 1'b1;
    end
  end

  // A fresh line is clean, a store hit marks it dirty
  always_ff @(posedge clk) begin
    if (refill_i) begin
      tag_mem[index_i] <= tag_i;
      dirty_q[index_i] <= 1'b0;
    end else if (set_dirty_i) begin
      dirty_q[index_i] <= 1'b1;
    end
  end

  // Lookup index delayed one cycle to line up with the data SRAM read
  always_ff @(posedge clk) begin
    idx_q <= index_i;
  end

  assign hit_o        = valid_q[idx_q] && (tag_mem[idx_q] == tag_i);
  assign dirty_o      = valid_q[idx_q] && dirty_q[idx_q];
  assign victim_tag_o = tag_mem[idx_q];

  // Only a store that hit in the cycle before may dirty a line
  a_dirty_after_hit: assert property (@(posedge clk) disable iff (rst_i)
    set_dirty_i |-> $past(hit_o))
    else $error("set_dirty without a preceding hit");

endmodule

// File: design/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_top
  import dcache_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic                      req_i,
  input  cpu_req_t                  cpu_req_i,
  output logic                      done_o,
  output word_t                     rdata_o,
  output logic                      mem_rd_o,
  output logic                      mem_wr_o,
  output logic [`DCACHE_ADDR_W-1:0] mem_addr_o,
  output word_t                     mem_wdata_o,
  input  word_t                     mem_rdata_i,
  input  logic                      mem_beat_i
);

  logic        hit;
  logic        dirty;
  logic        tag_refill;
  logic        tag_set_dirty;
  tag_t        victim_tag;
  index_t      index;
  blk_off_t    blk_addr;
  bank_word_t  line_wdata;
  bank_word_t  wmask;
  beat_t       burst_count;
  logic        allocate_valid;
  logic        writeback_valid;
  logic        wen;
  cache_addr_t line_addr;
  sram_port_t  sram_port [`DCACHE_BANKS];
  bank_word_t  sram_rdata [`DCACHE_BANKS];

  assign mem_addr_o = line_addr;

  dcache_ctrl u_dcache_ctrl (
    .clk               (clk),
    .rst_i             (rst_i),
    .req_i             (req_i),
    .cpu_req_i         (cpu_req_i),
    .done_o            (done_o),
    .hit_i             (hit),
    .dirty_i           (dirty),
    .victim_tag_i      (victim_tag),
    .tag_refill_o      (tag_refill),
    .tag_set_dirty_o   (tag_set_dirty),
    .index_o           (index),
    .blk_addr_o        (blk_addr),
    .line_wdata_o      (line_wdata),
    .wmask_o           (wmask),
    .burst_count_o     (burst_count),
    .allocate_valid_o  (allocate_valid),
    .writeback_valid_o (writeback_valid),
    .wen_o             (wen),
    .mem_rd_o          (mem_rd_o),
    .mem_wr_o          (mem_wr_o),
    .mem_addr_o        (line_addr),
    .mem_rdata_i       (mem_rdata_i),
    .mem_beat_i        (mem_beat_i)
  );

  // Compare tag taken from the line address, which holds the request tag
  // in every state but writeback
  dcache_tag u_dcache_tag (
    .clk          (clk),
    .rst_i        (rst_i),
    .index_i      (index),
    .tag_i        (line_addr.tag),
    .refill_i     (tag_refill),
    .set_dirty_i  (tag_set_dirty),
    .hit_o        (hit),
    .dirty_o      (dirty),
    .victim_tag_o (victim_tag)
  );

  dcache_data u_dcache_data (
    .clk               (clk),
    .index_i           (index),
    .blk_addr_i        (blk_addr),
    .line_wdata_i      (line_wdata),
    .wmask_i           (wmask),
    .burst_count_i     (burst_count),
    .allocate_valid_i  (allocate_valid),
    .writeback_valid_i (writeback_valid),
    .wen_i             (wen),
    .sram_o            (sram_port),
    .sram_rdata_i      (sram_rdata),
    .writeback_data_o  (mem_wdata_o),
    .rdata_o           (rdata_o)
  );

  for (genvar b = 0; b < `DCACHE_BANKS; b++) begin : g_bank
    sram_64x128 u_sram (
      .clk     (clk),
      .port_i  (sram_port[b]),
      .rdata_o (sram_rdata[b])
    );
  end

endmodule

// File: design/sram_64x128.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module sram_64x128
  import dcache_pkg::*;
(
  input  logic       clk,
  input  sram_port_t port_i,
  output bank_word_t rdata_o
);

  bank_word_t mem [0:`DCACHE_SETS-1];
  bank_word_t rdata_q;

  // Bit-masked write, mask bit set means the bit is written
  always_ff @(posedge clk) begin
    if (!port_i.cen && !port_i.wen) begin
      mem[port_i.addr] <= (mem[port_i.addr] & ~port_i.wmask) |
                          (port_i.wdata & port_i.wmask);
    end
  end

  // Read data shows up one cycle after the address
  // and holds while the bank is idle or writing
  always_ff @(posedge clk) begin
    if (!port_i.cen && port_i.wen) begin
      rdata_q <= mem[port_i.addr];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: testbench/dcache_tb.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_tb
  import dcache_pkg::*;
();

  localparam int   CLK_PERIOD      = 40;
  localparam int   NUM_TXN         = 400;
  localparam int   WATCHDOG_CYCLES = NUM_TXN * 40;
  localparam tag_t TAG_BASE        = 20'hA5C30;

  logic                      clk;
  logic                      rst_i;
  logic                      req_i;
  cpu_req_t                  cpu_req_i;
  logic                      done_o;
  word_t                     rdata_o;
  logic                      mem_rd_o;
  logic                      mem_wr_o;
  logic [`DCACHE_ADDR_W-1:0] mem_addr_o;
  word_t                     mem_wdata_o;
  word_t                     mem_rdata_i;
  logic                      mem_beat_i;

  logic [15:0] lfsr_state;
  int          errors;
  int          hits;

  // Expected contents of the 128 words the stimulus can reach
  word_t ref_mem [128];
  // Main memory behind the cache, changed only by writebacks
  word_t bus_mem [logic [31:0]];

  // Shadow of the direct-mapped tag store
  logic sh_valid [`DCACHE_SETS];
  logic sh_dirty [`DCACHE_SETS];
  tag_t sh_tag   [`DCACHE_SETS];

  dcache_top u_dcache_top (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_i       (req_i),
    .cpu_req_i   (cpu_req_i),
    .done_o      (done_o),
    .rdata_o     (rdata_o),
    .mem_rd_o    (mem_rd_o),
    .mem_wr_o    (mem_wr_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_rdata_i (mem_rdata_i),
    .mem_beat_i  (mem_beat_i)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1, shifting right
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  function automatic word_t fill_word(input logic [31:0] a);
    return {a ^ 32'hC3A5_0F96, a[15:0], a[31:16]};
  endfunction

  function automatic logic [31:0] line_base(input tag_t tag, input index_t idx);
    return {tag, idx, 6'b000000};
  endfunction

  // Tag pool entry, set group and word within the line
  function automatic logic [6:0] ref_slot(input tag_t tag, input index_t idx,
                                          input logic [2:0] w);
    return {tag[1:0], idx[5:4], w};
  endfunction

  function automatic word_t bus_read(input logic [31:0] a);
    if (bus_mem.exists(a)) begin
      return bus_mem[a];
    end
    return fill_word(a);
  endfunction

  function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                        input strb_t strb);
    word_t m;
    m = old_w;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) begin
        m[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return m;
  endfunction

  task automatic report_mismatch(input string name, input word_t got, input word_t want);
    $display("ERR %s got %h exp %h at %0t", name, got, want, $time);
    errors++;
  endtask

  task automatic report_failure(input string what);
    $display("Error at %0t: %s", $time, what);
    errors++;
  endtask

  // One random load or store, with the memory responder running until done_o
  task automatic run_access();
    cpu_req_t    req;
    index_t      idx;
    logic        hit;
    logic        dirty_victim;
    logic [31:0] req_line;
    logic [31:0] victim_line;
    logic [6:0]  slot;
    word_t       want;
    int          cycles;
    int          gap;
    int          first_rd;
    int          first_wr;
    int          rd_beats;
    int          wr_beats;
    logic        done;
    logic        beat;

    req.addr.tag    = TAG_BASE | tag_t'(2'(take_bits(2)));
    req.addr.index  = {2'(take_bits(2)), 4'h9};
    req.addr.offset = {3'(take_bits(3)), 3'b000};
    req.we          = 1'(take_bits(1));
    req.wstrb       = strb_t'(take_bits(8));
    req.wdata       = take_bits(64);
    idx             = req.addr.index;
    hit             = sh_valid[idx] && (sh_tag[idx] == req.addr.tag);
    dirty_victim    = sh_valid[idx] && !hit && sh_dirty[idx];
    req_line        = line_base(req.addr.tag, idx);
    victim_line     = line_base(sh_tag[idx], idx);
    slot            = ref_slot(req.addr.tag, idx, req.addr.offset[5:3]);

    cpu_req_i = req;
    req_i     = 1'b1;
    cycles    = 0;
    first_rd  = -1;
    first_wr  = -1;
    rd_beats  = 0;
    wr_beats  = 0;
    done      = 1'b0;
    gap       = int'(take_bits(2));
    while (!done) begin
      @(posedge clk);
      #2;
      cycles++;
      req_i = 1'b0;
      beat  = 1'b0;
      if (done_o === 1'b1) begin
        done = 1'b1;
        if (!req.we && rdata_o !== ref_mem[slot]) begin
          report_mismatch("rdata_o", rdata_o, ref_mem[slot]);
        end
      end else if (mem_wr_o === 1'b1) begin
        if (first_wr < 0) begin
          first_wr = cycles;
        end
        if (gap > 0) begin
          gap--;
        end else begin
          // Victim words in the cache are the newest copy
          want = ref_mem[ref_slot(sh_tag[idx], idx, 3'(wr_beats))];
          if (mem_wdata_o !== want) begin
            report_mismatch("mem_wdata_o", mem_wdata_o, want);
          end
          if (mem_addr_o !== victim_line) begin
            report_mismatch("mem_addr_o", word_t'(mem_addr_o), word_t'(victim_line));
          end
          bus_mem[victim_line + 32'(wr_beats * 8)] = mem_wdata_o;
          beat = 1'b1;
          wr_beats++;
          gap = int'(take_bits(2));
        end
      end else if (mem_rd_o === 1'b1) begin
        if (first_rd < 0) begin
          first_rd = cycles;
        end
        if (gap > 0) begin
          gap--;
        end else begin
          if (mem_addr_o !== req_line) begin
            report_mismatch("mem_addr_o", word_t'(mem_addr_o), word_t'(req_line));
          end
          mem_rdata_i = bus_read(req_line + 32'(rd_beats * 8));
          beat = 1'b1;
          rd_beats++;
          gap = int'(take_bits(2));
        end
      end
      mem_beat_i = beat;
    end

    if (hit) begin
      hits++;
      if (cycles != (req.we ? 2 : 1)) begin
        report_failure($sformatf("hit answered after %0d cycles", cycles));
      end
      if (first_rd >= 0 || first_wr >= 0) begin
        report_failure("memory burst on a predicted hit");
      end
    end else begin
      if (first_rd < 0) begin
        report_failure("miss finished without a refill burst");
      end
      if (rd_beats != `DCACHE_BEATS) begin
        report_failure($sformatf("refill burst took %0d beats", rd_beats));
      end
      if (dirty_victim) begin
        if (first_wr < 0 || first_wr > first_rd) begin
          report_failure("dirty victim not written back before the refill");
        end
        if (wr_beats != `DCACHE_BEATS) begin
          report_failure($sformatf("writeback burst took %0d beats", wr_beats));
        end
      end else if (first_wr >= 0) begin
        report_failure("writeback of a clean victim");
      end
    end

    if (!hit) begin
      sh_valid[idx] = 1'b1;
      sh_tag[idx]   = req.addr.tag;
      sh_dirty[idx] = 1'b0;
    end
    if (req.we) begin
      sh_dirty[idx] = 1'b1;
      ref_mem[slot] = merge_bytes(ref_mem[slot], req.wdata, req.wstrb);
    end

    // FSM is back in IDLE one cycle after done_o
    @(posedge clk);
    #2;
    if (done_o !== 1'b0) begin
      report_failure("done_o high for more than one cycle");
    end
  endtask

  initial begin
    rst_i       = 1'b1;
    req_i       = 1'b0;
    cpu_req_i   = '0;
    mem_rdata_i = '0;
    mem_beat_i  = 1'b0;
    lfsr_state  = 16'd77;
    errors      = 0;
    hits        = 0;
    for (int k = 0; k < 128; k++) begin
      ref_mem[k] = fill_word({TAG_BASE | tag_t'(k[6:5]), k[4:3], 4'h9, k[2:0], 3'b000});
    end
    for (int i = 0; i < `DCACHE_SETS; i++) begin
      sh_valid[i] = 1'b0;
      sh_dirty[i] = 1'b0;
      sh_tag[i]   = '0;
    end

    repeat (2) @(posedge clk);
    #2;
    rst_i = 1'b0;

    // Quiet outputs before the first request
    repeat (3) begin
      @(posedge clk);
      #2;
      if (done_o !== 1'b0 || mem_rd_o !== 1'b0 || mem_wr_o !== 1'b0) begin
        report_failure("output active after reset with no request");
      end
    end

    for (int n = 0; n < NUM_TXN; n++) begin
      run_access();
    end

    $display("Finished %0d accesses, %0d hits, %0d errors", NUM_TXN, hits, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles with accesses still running",
             WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule
